/* common/lsq_macros.svh */
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// number of load queue entries, must be a power of two
`define LQ_SIZE 8

// byte address width
`define ADDR_WIDTH 32

// data width, also the size of one memory block
`define DATA_WIDTH 64

// destination register index width
`define REG_BITS 5

`endif

/* common/lsq_pkg.sv */
`include "lsq_macros.svh"

package lsq_pkg;

    // access size of a load
    typedef enum logic [1:0] {
        LD_BYTE   = 2'd0,
        LD_HALF   = 2'd1,
        LD_WORD   = 2'd2,
        LD_DOUBLE = 2'd3
    } mem_op_t;

    // miss requester handshake state
    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        WAIT_ACK     = 2'd1,
        WAIT_RELEASE = 2'd2
    } fill_state_t;

    // one row of the load queue
    typedef struct packed {
        logic                   valid;
        logic                   requested;
        logic                   data_valid;
        mem_op_t                op;
        logic [`REG_BITS-1:0]   dest_reg;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
    } lq_entry_t;

endpackage

/* hw/load_issue.sv */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module load_issue import lsq_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   in_valid,
    input  logic [`ADDR_WIDTH-1:0] in_base,
    input  logic [`ADDR_WIDTH-1:0] in_offset,
    input  mem_op_t                in_op,
    input  logic [`REG_BITS-1:0]   in_dest,
    output logic                   in_ready,

    input  logic                   full,
    output logic                   enq_valid,
    output logic [`ADDR_WIDTH-1:0] enq_addr,
    output mem_op_t                enq_op,
    output logic [`REG_BITS-1:0]   enq_dest
);

    logic stage_valid;

    // the held load moves into the queue whenever there is room
    assign enq_valid = stage_valid && !full;
    assign in_ready  = !stage_valid || !full;

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            stage_valid <= 1'b1;
        end else if (enq_valid) begin
            stage_valid <= 1'b0;
        end
    end

    // address generation
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            enq_addr <= in_base + in_offset;
            enq_op   <= in_op;
            enq_dest <= in_dest;
        end
    end

    // queue must never be written while full
    assert property (@(posedge clock) disable iff (reset)
        !(enq_valid && full));

endmodule

/* hw/load_queue/load_queue.sv */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module load_queue import lsq_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   enq_valid,
    input  logic [`ADDR_WIDTH-1:0] enq_addr,
    input  mem_op_t                enq_op,
    input  logic [`REG_BITS-1:0]   enq_dest,
    output logic                   full,

    output logic                   miss_valid,
    output logic [`ADDR_WIDTH-1:0] miss_addr,
    input  logic                   miss_ack,

    input  logic                   fill_valid,
    input  logic [`ADDR_WIDTH-1:0] fill_addr,
    input  logic [`DATA_WIDTH-1:0] fill_data,

    output logic                   head_valid,
    output logic [`ADDR_WIDTH-1:0] head_addr,
    output mem_op_t                head_op,
    output logic [`DATA_WIDTH-1:0] head_data,
    output logic [`REG_BITS-1:0]   head_dest,
    input  logic                   pop
);

    localparam int IDX_BITS = $clog2(`LQ_SIZE);
    // byte offset bits inside one block
    localparam int OFS_BITS = $clog2(`DATA_WIDTH / 8);

    lq_entry_t [`LQ_SIZE-1:0] rows;
    logic [IDX_BITS-1:0]      head;
    logic [IDX_BITS-1:0]      tail;
    logic [IDX_BITS-1:0]      miss_idx;
    logic [`LQ_SIZE-1:0]      fill_hit;
    logic [`LQ_SIZE-1:0]      req_bits;
    logic                     enq_hit;

    assign full = (tail + 1'b1) == head;

    // parallel block match of the returning fill
    always_comb begin
        for (int i = 0; i < `LQ_SIZE; i++) begin
            fill_hit[i] = fill_valid && rows[i].valid &&
                (rows[i].addr[`ADDR_WIDTH-1:OFS_BITS] == fill_addr[`ADDR_WIDTH-1:OFS_BITS]);
            req_bits[i] = rows[i].requested;
        end
    end

    // a load arriving together with its block takes the data directly
    assign enq_hit = fill_valid &&
        (enq_addr[`ADDR_WIDTH-1:OFS_BITS] == fill_addr[`ADDR_WIDTH-1:OFS_BITS]);

    // oldest unrequested miss, scanning from the head
    always_comb begin
        logic [IDX_BITS-1:0] idx;
        miss_valid = 1'b0;
        miss_idx   = head;
        for (int i = 0; i < `LQ_SIZE; i++) begin
            idx = head + IDX_BITS'(i);
            if (!miss_valid && rows[idx].valid && !rows[idx].requested &&
                    !rows[idx].data_valid) begin
                miss_valid = 1'b1;
                miss_idx   = idx;
            end
        end
    end

    assign miss_addr = {rows[miss_idx].addr[`ADDR_WIDTH-1:OFS_BITS], {OFS_BITS{1'b0}}};

    assign head_valid = rows[head].valid && rows[head].data_valid;
    assign head_addr  = rows[head].addr;
    assign head_op    = rows[head].op;
    assign head_data  = rows[head].data;
    assign head_dest  = rows[head].dest_reg;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `LQ_SIZE; i++) begin
                rows[i].valid      <= 1'b0;
                rows[i].requested  <= 1'b0;
                rows[i].data_valid <= 1'b0;
            end
            head <= '0;
            tail <= '0;
        end else begin
            for (int i = 0; i < `LQ_SIZE; i++) begin
                if (fill_hit[i]) begin
                    rows[i].data       <= fill_data;
                    rows[i].data_valid <= 1'b1;
                end
            end
            if (miss_ack) begin
                rows[miss_idx].requested <= 1'b1;
            end
            if (pop) begin
                rows[head].valid <= 1'b0;
                head             <= head + 1'b1;
            end
            // tail slot is always empty, so no clash with the updates above
            if (enq_valid) begin
                rows[tail].valid      <= 1'b1;
                rows[tail].requested  <= 1'b0;
                rows[tail].data_valid <= enq_hit;
                rows[tail].op         <= enq_op;
                rows[tail].dest_reg   <= enq_dest;
                rows[tail].addr       <= enq_addr;
                rows[tail].data       <= fill_data;
                tail                  <= tail + 1'b1;
            end
        end
    end

    // writeback only takes a head that already has its data
    assert property (@(posedge clock) disable iff (reset)
        pop |-> head_valid);

    // every fill answers a request made for a queued load
    assert property (@(posedge clock) disable iff (reset)
        fill_valid |-> |(fill_hit & req_bits));

endmodule

/* hw/miss_requester.sv */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module miss_requester import lsq_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   miss_valid,
    input  logic [`ADDR_WIDTH-1:0] miss_addr,
    output logic                   miss_ack,

    output logic                   fill_valid,
    output logic [`ADDR_WIDTH-1:0] fill_addr,
    output logic [`DATA_WIDTH-1:0] fill_data,

    output logic                   mem_req,
    output logic [`ADDR_WIDTH-1:0] mem_addr,
    input  logic                   mem_ack,
    input  logic [`DATA_WIDTH-1:0] mem_rdata
);

    fill_state_t state;

    // the latched block address tags the returning data
    assign fill_addr = mem_addr;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            mem_req    <= 1'b0;
            miss_ack   <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            miss_ack   <= 1'b0;
            fill_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (miss_valid) begin
                        mem_req  <= 1'b1;
                        miss_ack <= 1'b1;
                        state    <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (mem_ack) begin
                        mem_req    <= 1'b0;
                        fill_valid <= 1'b1;
                        state      <= WAIT_RELEASE;
                    end
                end
                WAIT_RELEASE: begin
                    // four-phase: wait for memory to drop ack
                    if (!mem_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge clock) begin
        if (state == IDLE && miss_valid) begin
            mem_addr <= miss_addr;
        end
        if (state == WAIT_ACK && mem_ack) begin
            fill_data <= mem_rdata;
        end
    end

    // request held with a steady address until memory answers
    assert property (@(posedge clock) disable iff (reset)
        (state == WAIT_ACK && !mem_ack) |=> (mem_req && $stable(mem_addr)));

endmodule

/* hw/load_writeback.sv */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module load_writeback import lsq_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   head_valid,
    input  logic [`ADDR_WIDTH-1:0] head_addr,
    input  mem_op_t                head_op,
    input  logic [`DATA_WIDTH-1:0] head_data,
    input  logic [`REG_BITS-1:0]   head_dest,
    output logic                   pop,

    output logic                   result_valid,
    output logic [`DATA_WIDTH-1:0] result_data,
    output logic [`REG_BITS-1:0]   result_dest,
    input  logic                   result_ready
);

    localparam int OFS_BITS = $clog2(`DATA_WIDTH / 8);

    logic [`DATA_WIDTH-1:0] shifted;
    logic [`DATA_WIDTH-1:0] extracted;

    // take the head when the output register is free or draining
    assign pop = head_valid && (!result_valid || result_ready);

    // byte offset times eight gives the bit shift
    assign shifted = head_data >> {head_addr[OFS_BITS-1:0], 3'b000};

    // zero extend to the access size
    always_comb begin
        case (head_op)
            LD_BYTE:   extracted = {{(`DATA_WIDTH - 8){1'b0}}, shifted[7:0]};
            LD_HALF:   extracted = {{(`DATA_WIDTH - 16){1'b0}}, shifted[15:0]};
            LD_WORD:   extracted = {{(`DATA_WIDTH - 32){1'b0}}, shifted[31:0]};
            LD_DOUBLE: extracted = shifted;
            default:   extracted = shifted;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (pop) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    // result payload
    always_ff @(posedge clock) begin
        if (pop) begin
            result_data <= extracted;
            result_dest <= head_dest;
        end
    end

endmodule

/* hw/load_pipe_top.sv */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module load_pipe_top import lsq_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   in_valid,
    input  logic [`ADDR_WIDTH-1:0] in_base,
    input  logic [`ADDR_WIDTH-1:0] in_offset,
    input  mem_op_t                in_op,
    input  logic [`REG_BITS-1:0]   in_dest,
    output logic                   in_ready,

    output logic                   mem_req,
    output logic [`ADDR_WIDTH-1:0] mem_addr,
    input  logic                   mem_ack,
    input  logic [`DATA_WIDTH-1:0] mem_rdata,

    output logic                   result_valid,
    output logic [`DATA_WIDTH-1:0] result_data,
    output logic [`REG_BITS-1:0]   result_dest,
    input  logic                   result_ready
);

    // issue to queue
    logic                   enq_valid;
    logic [`ADDR_WIDTH-1:0] enq_addr;
    mem_op_t                enq_op;
    logic [`REG_BITS-1:0]   enq_dest;
    logic                   full;

    // queue to requester and back
    logic                   miss_valid;
    logic [`ADDR_WIDTH-1:0] miss_addr;
    logic                   miss_ack;
    logic                   fill_valid;
    logic [`ADDR_WIDTH-1:0] fill_addr;
    logic [`DATA_WIDTH-1:0] fill_data;

    // queue head to writeback
    logic                   head_valid;
    logic [`ADDR_WIDTH-1:0] head_addr;
    mem_op_t                head_op;
    logic [`DATA_WIDTH-1:0] head_data;
    logic [`REG_BITS-1:0]   head_dest;
    logic                   pop;

    load_issue u_issue (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_base   (in_base),
        .in_offset (in_offset),
        .in_op     (in_op),
        .in_dest   (in_dest),
        .in_ready  (in_ready),
        .full      (full),
        .enq_valid (enq_valid),
        .enq_addr  (enq_addr),
        .enq_op    (enq_op),
        .enq_dest  (enq_dest)
    );

    load_queue u_queue (
        .clock      (clock),
        .reset      (reset),
        .enq_valid  (enq_valid),
        .enq_addr   (enq_addr),
        .enq_op     (enq_op),
        .enq_dest   (enq_dest),
        .full       (full),
        .miss_valid (miss_valid),
        .miss_addr  (miss_addr),
        .miss_ack   (miss_ack),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_op    (head_op),
        .head_data  (head_data),
        .head_dest  (head_dest),
        .pop        (pop)
    );

    miss_requester u_requester (
        .clock      (clock),
        .reset      (reset),
        .miss_valid (miss_valid),
        .miss_addr  (miss_addr),
        .miss_ack   (miss_ack),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    load_writeback u_writeback (
        .clock        (clock),
        .reset        (reset),
        .head_valid   (head_valid),
        .head_addr    (head_addr),
        .head_op      (head_op),
        .head_data    (head_data),
        .head_dest    (head_dest),
        .pop          (pop),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest),
        .result_ready (result_ready)
    );

endmodule

/* tb/mem_model.sv */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module mem_model (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   mem_req,
    input  logic [`ADDR_WIDTH-1:0] mem_addr,
    output logic                   mem_ack,
    output logic [`DATA_WIDTH-1:0] mem_rdata
);

    logic [15:0] lfsr_state;
    logic [2:0]  wait_count;
    logic        busy;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // three steps give a delay of 0 to 7 cycles
    function automatic logic [2:0] pick_delay();
        logic [2:0] d;
        for (int k = 0; k < 3; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            d[k] = lfsr_state[0];
        end
        return d;
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            lfsr_state = 16'd80;
            busy       <= 1'b0;
            wait_count <= '0;
            mem_ack    <= 1'b0;
            mem_rdata  <= '0;
        end else if (mem_ack) begin
            // release once the request is withdrawn
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (busy) begin
            if (wait_count == 0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= {mem_addr, ~mem_addr};
                busy      <= 1'b0;
            end else begin
                wait_count <= wait_count - 1'b1;
            end
        end else if (mem_req) begin
            busy       <= 1'b1;
            wait_count <= pick_delay();
        end
    end

endmodule

/* tb/load_pipe_tb.sv */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module load_pipe_tb import lsq_pkg::*; ();

    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] base;
        logic [`ADDR_WIDTH-1:0] offset;
        mem_op_t                op;
        logic [`REG_BITS-1:0]   dest;
        // handshakes expected when a group ends here, -1 inside a group
        int                     reqs;
        // group runs with the result side held off
        logic                   stall;
    } load_t;

    logic                   clock;
    logic                   reset;
    logic                   in_valid;
    logic [`ADDR_WIDTH-1:0] in_base;
    logic [`ADDR_WIDTH-1:0] in_offset;
    mem_op_t                in_op;
    logic [`REG_BITS-1:0]   in_dest;
    logic                   in_ready;
    logic                   mem_req;
    logic [`ADDR_WIDTH-1:0] mem_addr;
    logic                   mem_ack;
    logic [`DATA_WIDTH-1:0] mem_rdata;
    logic                   result_valid;
    logic [`DATA_WIDTH-1:0] result_data;
    logic [`REG_BITS-1:0]   result_dest;
    logic                   result_ready;

    load_t                  loads[$];
    logic [`DATA_WIDTH-1:0] exp_data[$];
    logic [`REG_BITS-1:0]   exp_dest[$];
    int                     errors = 0;
    int                     results = 0;
    int                     handshakes = 0;
    int                     cycles = 0;
    int                     cycle_limit = 0;
    int                     stall_cycles = 0;
    int                     ready_run = 0;
    logic                   req_seen = 1'b0;
    logic                   hold_ready = 1'b0;
    logic                   saw_full = 1'b0;
    logic [15:0]            ready_lfsr = 16'd80;

    load_pipe_top UUT (.*);

    mem_model u_mem (
        .clock     (clock),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic int draw_bits(input int count);
        int bits;
        bits = 0;
        for (int k = 0; k < count; k++) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            bits = (bits << 1) | ready_lfsr[0];
        end
        return bits;
    endfunction

    // memory block is {block address, inverted block address}
    function automatic logic [`DATA_WIDTH-1:0] expected_value(
            input logic [`ADDR_WIDTH-1:0] addr, input mem_op_t op);
        logic [`ADDR_WIDTH-1:0] block;
        logic [`DATA_WIDTH-1:0] line;
        logic [`DATA_WIDTH-1:0] value;
        int                     ofs;
        block = {addr[`ADDR_WIDTH-1:3], 3'b000};
        line  = {block, ~block};
        ofs   = addr[2:0];
        value = '0;
        for (int k = 0; k < (1 << int'(op)); k++) begin
            value[8*k +: 8] = line[8*(ofs+k) +: 8];
        end
        return value;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
            input logic [63:0] want);
        if (got !== want) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic add_load(input logic [31:0] base, input logic [31:0] offset,
            input mem_op_t op, input logic [4:0] dest, input int reqs, input logic stall);
        loads.push_back({base, offset, op, dest, reqs, stall});
    endtask

    task automatic build_table();
        mem_op_t op;
        // sizes and offsets within one block
        add_load(32'h1000, 32'd0, LD_BYTE, 5'd1, -1, 1'b0);
        add_load(32'h1000, 32'd5, LD_BYTE, 5'd2, -1, 1'b0);
        add_load(32'h0ffe, 32'd4, LD_HALF, 5'd3, -1, 1'b0);
        add_load(32'h1000, 32'd6, LD_HALF, 5'd4, 1, 1'b0);
        add_load(32'h2040, 32'd0, LD_WORD, 5'd5, -1, 1'b0);
        add_load(32'h2000, 32'h44, LD_WORD, 5'd6, -1, 1'b0);
        add_load(32'h2040, 32'd0, LD_DOUBLE, 5'd7, -1, 1'b0);
        add_load(32'h2047, 32'd0, LD_BYTE, 5'd8, 1, 1'b0);
        // burst to one block while its fill is pending
        add_load(32'h2ff8, 32'd8, LD_WORD, 5'd9, -1, 1'b0);
        add_load(32'h3000, 32'd1, LD_BYTE, 5'd10, -1, 1'b0);
        add_load(32'h3004, 32'd2, LD_HALF, 5'd11, -1, 1'b0);
        add_load(32'h3000, 32'd4, LD_WORD, 5'd12, -1, 1'b0);
        add_load(32'h3000, 32'd0, LD_DOUBLE, 5'd13, 1, 1'b0);
        // distinct blocks
        add_load(32'h4000, 32'd0, LD_DOUBLE, 5'd14, -1, 1'b0);
        add_load(32'h5000, 32'hc, LD_WORD, 5'd15, -1, 1'b0);
        add_load(32'h6010, 32'd2, LD_HALF, 5'd16, -1, 1'b0);
        add_load(32'h7018, 32'd3, LD_BYTE, 5'd17, -1, 1'b0);
        add_load(32'h8020, 32'd0, LD_DOUBLE, 5'd18, 5, 1'b0);
        // more loads than the pipe can hold with results blocked
        for (int k = 0; k < 10; k++) begin
            op = mem_op_t'(k % 4);
            add_load(32'h9000 + 8 * k, (k & 1) ? (8 - (1 << int'(op))) : 0, op,
                5'(20 + k), (k == 9) ? 10 : -1, k == 0);
        end
        cycle_limit = 200 * loads.size();
    endtask

    // caller sits on a rising edge, returns on the transfer edge
    task automatic send_load(input load_t ld);
        in_valid  <= 1'b1;
        in_base   <= ld.base;
        in_offset <= ld.offset;
        in_op     <= ld.op;
        in_dest   <= ld.dest;
        exp_data.push_back(expected_value(ld.base + ld.offset, ld.op));
        exp_dest.push_back(ld.dest);
        @(negedge clock);
        while (!in_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
    endtask

    // result side stalls in random stretches
    always @(posedge clock) begin
        if (hold_ready) begin
            result_ready <= 1'b0;
        end else if (ready_run != 0) begin
            ready_run <= ready_run - 1;
        end else begin
            result_ready <= (draw_bits(1) != 0);
            ready_run    <= draw_bits(2);
        end
    end

    always @(negedge clock) begin
        if (!reset) begin
            if (mem_req && !req_seen) begin
                handshakes++;
            end
            req_seen = mem_req;
            if (result_valid && result_ready) begin
                if (exp_data.size() == 0) begin
                    $display("A result for register %0d came out with no load outstanding",
                        result_dest);
                    errors++;
                end else begin
                    check_value("result data", result_data, exp_data.pop_front());
                    check_value("result dest", result_dest, exp_dest.pop_front());
                    results++;
                end
            end
            // result side held off for a fixed stretch, input stall noted
            if (hold_ready) begin
                if (!in_ready) begin
                    saw_full = 1'b1;
                end
                stall_cycles++;
                if (stall_cycles == 40) begin
                    hold_ready   = 1'b0;
                    stall_cycles = 0;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit + 16) begin
            $display("Timeout: the loads did not all complete within %0d cycles, %0d errors",
                cycle_limit, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int group_start;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_base      = '0;
        in_offset    = '0;
        in_op        = LD_BYTE;
        in_dest      = '0;
        result_ready = 1'b1;
        build_table();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("in_ready after reset", in_ready, 1);
        check_value("mem_req after reset", mem_req, 0);
        check_value("result_valid after reset", result_valid, 0);
        @(posedge clock);
        group_start = handshakes;
        for (int i = 0; i < loads.size(); i++) begin
            if (loads[i].stall) begin
                @(negedge clock);
                hold_ready = 1'b1;
                saw_full   = 1'b0;
                @(posedge clock);
            end
            send_load(loads[i]);
            if (loads[i].reqs >= 0) begin
                in_valid <= 1'b0;
                while (exp_data.size() != 0) begin
                    @(negedge clock);
                end
                check_value("memory handshakes", handshakes - group_start, loads[i].reqs);
                if (loads[i].reqs == 10) begin
                    check_value("in_ready dropped under back-pressure", saw_full, 1);
                end
                group_start = handshakes;
                @(posedge clock);
            end
        end
        check_value("result count", results, loads.size());
        $display("Done: %0d loads, %0d results, %0d handshakes, %0d errors",
            loads.size(), results, handshakes, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/lsq_pkg.sv
hw/load_issue.sv
hw/load_queue/load_queue.sv
hw/miss_requester.sv
hw/load_writeback.sv
hw/load_pipe_top.sv
tb/mem_model.sv
tb/load_pipe_tb.sv

/* Bender.yml */
package:
  name: load_pipe

export_include_dirs:
  - common

sources:
  - files:
      - common/lsq_pkg.sv
      - hw/load_issue.sv
      - hw/load_queue/load_queue.sv
      - hw/miss_requester.sv
      - hw/load_writeback.sv
      - hw/load_pipe_top.sv
  - target: test
    files:
      - tb/mem_model.sv
      - tb/load_pipe_tb.sv
